// ==== hdl/shiftPkg.sv ====
`default_nettype none

package shiftPkg;

    localparam int DataWidth = 64;

    typedef logic [DataWidth-1:0] dataT;
    typedef logic [7:0]           amountT;

    typedef enum logic [2:0] {
        opSll,
        opSrl,
        opSra,
        opRol,
        opRor
    } shiftOpT;

    // One side of a four-phase req/ack exchange
    typedef enum logic [1:0] {
        hsIdle,
        hsBusy,
        hsDone
    } hsStateT;

    // How the execute stage merges the side shifter into the main result
    localparam logic [1:0] ModePlain  = 2'd0;
    localparam logic [1:0] ModeRotate = 2'd1;
    localparam logic [1:0] ModeFill   = 2'd2;

endpackage

`default_nettype wire

// ==== hdl/shiftLeft64.sv ====
`timescale 1ns/1ns
`default_nettype none

module shiftLeft64 #(
    parameter int Width = 64
) (
    input  wire shiftPkg::amountT n,
    input  wire [Width-1:0]       in,
    output logic [Width-1:0]      out
);

    localparam int Stages = $clog2(Width);

    logic [Width-1:0] stage [Stages+1];

    assign stage[0] = in;

    // Each stage moves the word by one power of two when its amount bit is set
    for (genvar i = 0; i < Stages; i++) begin : gStage
        assign stage[i+1] = n[i] ? (stage[i] << (2 ** i)) : stage[i];
    end

    // Every bit falls off the top once the amount reaches the width
    assign out = (n >= Width) ? '0 : stage[Stages];

endmodule

`default_nettype wire

// ==== hdl/shiftDecode.sv ====
`timescale 1ns/1ns
`default_nettype none

module shiftDecode (
    input  wire                     clk,
    input  wire                     arstN,
    input  wire                     cmdReq,
    output logic                    cmdAck,
    input  wire shiftPkg::shiftOpT  cmdOp,
    input  wire shiftPkg::dataT     cmdData,
    input  wire shiftPkg::amountT   cmdAmount,
    output logic                    decValid,
    input  wire                     exeTaken,
    output shiftPkg::dataT          decData,
    output logic                    decReverse,
    output shiftPkg::amountT        decAmountMain,
    output shiftPkg::amountT        decAmountSide,
    output logic [1:0]              decMode
);
    import shiftPkg::*;

    hsStateT    state;
    logic       accept;
    amountT     rotAmount;
    logic       nextReverse;
    amountT     nextAmountMain;
    amountT     nextAmountSide;
    logic [1:0] nextMode;

    // Take a command only while idle and with room in the holding register
    assign accept    = (state == hsIdle) && cmdReq && (!decValid || exeTaken);
    assign rotAmount = {2'b00, cmdAmount[5:0]};  // Rotates only see the amount modulo 64

    always_comb begin
        nextReverse    = (cmdOp == opSrl) || (cmdOp == opSra) || (cmdOp == opRor);
        nextAmountMain = cmdAmount;
        nextAmountSide = '0;
        nextMode       = ModePlain;
        case (cmdOp)
            opRol, opRor: begin
                nextAmountMain = rotAmount;
                nextAmountSide = 8'd64 - rotAmount;  // Partner part comes from the far end
                nextMode       = ModeRotate;
            end
            opSra: begin
                nextAmountSide = cmdAmount;
                if (cmdData[DataWidth-1]) nextMode = ModeFill;
            end
            default: ;
        endcase
    end

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            state    <= hsIdle;
            cmdAck   <= 1'b0;
            decValid <= 1'b0;
        end else begin
            case (state)
                hsIdle: if (accept) begin
                    state  <= hsBusy;
                    cmdAck <= 1'b1;
                end
                hsBusy: if (!cmdReq) begin  // Requester has let go, close the cycle
                    state  <= hsIdle;
                    cmdAck <= 1'b0;
                end
                default: state <= hsIdle;
            endcase
            if (accept) decValid <= 1'b1;
            else if (exeTaken) decValid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            decData       <= cmdData;
            decReverse    <= nextReverse;
            decAmountMain <= nextAmountMain;
            decAmountSide <= nextAmountSide;
            decMode       <= nextMode;
        end
    end

endmodule

`default_nettype wire

// ==== hdl/shiftExecute.sv ====
`timescale 1ns/1ns
`default_nettype none

module shiftExecute #(
    parameter int Width = shiftPkg::DataWidth
) (
    input  wire                   clk,
    input  wire                   arstN,
    input  wire                   decValid,
    output logic                  exeTaken,
    input  wire shiftPkg::dataT   decData,
    input  wire                   decReverse,
    input  wire shiftPkg::amountT decAmountMain,
    input  wire shiftPkg::amountT decAmountSide,
    input  wire [1:0]             decMode,
    output logic                  exeValid,
    output shiftPkg::dataT        exeData,
    input  wire                   resTaken
);
    import shiftPkg::*;

    logic             ctlValid;
    logic             ctlReverse;
    amountT           ctlAmountMain;
    amountT           ctlAmountSide;
    logic [1:0]       ctlMode;
    logic [Width-1:0] opMain;
    logic [Width-1:0] opSide;
    logic [Width-1:0] sideIn;
    logic [Width-1:0] mainOut;
    logic [Width-1:0] sideOut;
    logic [Width-1:0] combined;

    function automatic logic [Width-1:0] reverseBits(input logic [Width-1:0] v);
        logic [Width-1:0] r;
        for (int i = 0; i < Width; i++) r[i] = v[Width-1-i];
        return r;
    endfunction

    // One item at a time, the result register must be free by the time it is needed
    assign exeTaken = decValid && !ctlValid && (!exeValid || resTaken);

    assign sideIn = (ctlMode == ModeFill) ? '1 : opSide;  // All ones shifted gives the fill mask

    shiftLeft64 #(.Width(Width)) shiftMain (.n(ctlAmountMain), .in(opMain), .out(mainOut));
    shiftLeft64 #(.Width(Width)) shiftSide (.n(ctlAmountSide), .in(sideIn), .out(sideOut));

    always_comb begin
        case (ctlMode)
            ModeRotate: combined = mainOut | reverseBits(sideOut);
            ModeFill:   combined = mainOut | ~sideOut;
            default:    combined = mainOut;
        endcase
    end

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            ctlValid <= 1'b0;
            exeValid <= 1'b0;
        end else begin
            ctlValid <= exeTaken;
            if (ctlValid) exeValid <= 1'b1;
            else if (resTaken) exeValid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (exeTaken) begin
            opMain        <= decReverse ? reverseBits(decData) : decData;
            opSide        <= decReverse ? decData : reverseBits(decData);
            ctlReverse    <= decReverse;
            ctlAmountMain <= decAmountMain;
            ctlAmountSide <= decAmountSide;
            ctlMode       <= decMode;
        end
        if (ctlValid) exeData <= ctlReverse ? reverseBits(combined) : combined;
    end

endmodule

`default_nettype wire

// ==== hdl/shiftResult.sv ====
`timescale 1ns/1ns
`default_nettype none

module shiftResult (
    input  wire                 clk,
    input  wire                 arstN,
    input  wire                 exeValid,
    input  wire shiftPkg::dataT exeData,
    output logic                resTaken,
    output logic                rspReq,
    input  wire                 rspAck,
    output shiftPkg::dataT      rspData,
    output logic                rspZero
);
    import shiftPkg::*;

    hsStateT state;

    // The holder is free when idle, or when the consumer finishes in this cycle
    assign resTaken = exeValid && ((state == hsIdle) || ((state == hsDone) && !rspAck));

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            state  <= hsIdle;
            rspReq <= 1'b0;
        end else if (resTaken) begin
            state  <= hsBusy;
            rspReq <= 1'b1;
        end else begin
            case (state)
                hsBusy: if (rspAck) begin
                    state  <= hsDone;
                    rspReq <= 1'b0;
                end
                hsDone: if (!rspAck) state <= hsIdle;  // Four-phase cycle complete
                default: ;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (resTaken) begin
            rspData <= exeData;
            rspZero <= (exeData == '0);
        end
    end

endmodule

`default_nettype wire

// ==== hdl/shiftUnit.sv ====
`timescale 1ns/1ns
`default_nettype none

module shiftUnit (
    input  wire                    clk,
    input  wire                    arstN,
    input  wire                    cmdReq,
    output logic                   cmdAck,
    input  wire shiftPkg::shiftOpT cmdOp,
    input  wire shiftPkg::dataT    cmdData,
    input  wire shiftPkg::amountT  cmdAmount,
    output logic                   rspReq,
    input  wire                    rspAck,
    output shiftPkg::dataT         rspData,
    output logic                   rspZero
);
    import shiftPkg::*;

    logic       decValid;
    logic       exeTaken;
    dataT       decData;
    logic       decReverse;
    amountT     decAmountMain;
    amountT     decAmountSide;
    logic [1:0] decMode;
    logic       exeValid;
    dataT       exeData;
    logic       resTaken;

    shiftDecode decode (
        .clk(clk), .arstN(arstN),
        .cmdReq(cmdReq), .cmdAck(cmdAck), .cmdOp(cmdOp), .cmdData(cmdData),
        .cmdAmount(cmdAmount), .decValid(decValid), .exeTaken(exeTaken),
        .decData(decData), .decReverse(decReverse), .decAmountMain(decAmountMain),
        .decAmountSide(decAmountSide), .decMode(decMode)
    );

    shiftExecute #(.Width(DataWidth)) execute (
        .clk(clk), .arstN(arstN),
        .decValid(decValid), .exeTaken(exeTaken), .decData(decData),
        .decReverse(decReverse), .decAmountMain(decAmountMain),
        .decAmountSide(decAmountSide), .decMode(decMode),
        .exeValid(exeValid), .exeData(exeData), .resTaken(resTaken)
    );

    shiftResult result (
        .clk(clk), .arstN(arstN),
        .exeValid(exeValid), .exeData(exeData), .resTaken(resTaken),
        .rspReq(rspReq), .rspAck(rspAck), .rspData(rspData), .rspZero(rspZero)
    );

endmodule

`default_nettype wire

// ==== sim/shiftUnit_assert.sv ====
`timescale 1ns/1ns
`default_nettype none

module shiftUnitAssert (
    input wire                 clk,
    input wire                 arstN,
    input wire                 cmdReq,
    input wire                 cmdAck,
    input wire                 rspReq,
    input wire                 rspAck,
    input wire shiftPkg::dataT rspData
);

    // The unit only answers a command that is being offered
    ackNeedsReq: assert property (@(posedge clk) disable iff (!arstN)
        $rose(cmdAck) |-> $past(cmdReq))
        else $error("cmdAck rose while cmdReq was low");

    rspHeldUntilAck: assert property (@(posedge clk) disable iff (!arstN)
        rspReq && !rspAck |=> rspReq && $stable(rspData))
        else $error("rspReq dropped or rspData changed before rspAck");

    quietAfterReset: assert property (@(posedge clk)
        $rose(arstN) |-> !cmdReq && !cmdAck && !rspReq && !rspAck)
        else $error("handshake signal high in the first cycle after reset");

endmodule

bind shiftUnit shiftUnitAssert handshakeChecks (
    .clk(clk), .arstN(arstN), .cmdReq(cmdReq), .cmdAck(cmdAck),
    .rspReq(rspReq), .rspAck(rspAck), .rspData(rspData)
);

`default_nettype wire

// ==== sim/shiftUnitTb.sv ====
`timescale 1ns/1ns
`default_nettype none

module shiftUnitTb;
    import shiftPkg::*;

    localparam int          NumCmds   = 300;
    localparam int          WaitLimit = 200;
    localparam int unsigned Seed      = 32'ha2fad1c7;

    logic    clk;
    logic    arstN;
    logic    cmdReq;
    logic    cmdAck;
    shiftOpT cmdOp;
    dataT    cmdData;
    amountT  cmdAmount;
    logic    rspReq;
    logic    rspAck;
    dataT    rspData;
    logic    rspZero;

    dataT  expQ[$];  // Expected results in command order
    string nameQ[$];
    int    received;

    shiftUnit dut (
        .clk(clk), .arstN(arstN),
        .cmdReq(cmdReq), .cmdAck(cmdAck), .cmdOp(cmdOp), .cmdData(cmdData),
        .cmdAmount(cmdAmount), .rspReq(rspReq), .rspAck(rspAck),
        .rspData(rspData), .rspZero(rspZero)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    task automatic abortRun(input string why);
        $display("%s", why);
        $display("*** TEST FAILED ***");
        $fatal(1, "simulation stopped");
    endtask

    task automatic checkData(input string name, input dataT expected, input dataT actual);
        if (actual !== expected) begin
            $display("CHECK FAILED: %s expected %h actual %h", name, expected, actual);
            $display("*** TEST FAILED ***");
            $fatal(1, "result mismatch");
        end
    endtask

    task automatic checkZero(input string name, input logic expected, input logic actual);
        if (actual !== expected) begin
            $display("CHECK FAILED: %s expected %b actual %b", name, expected, actual);
            $display("*** TEST FAILED ***");
            $fatal(1, "zero flag mismatch");
        end
    endtask

    // Reference result for one command
    function automatic dataT modelShift(input shiftOpT op, input dataT data, input amountT amount);
        amountT rot;
        dataT   result;
        rot = amount % 8'd64;
        case (op)
            opSll: result = (amount >= 8'd64) ? '0 : data << amount;
            opSrl: result = (amount >= 8'd64) ? '0 : data >> amount;
            opSra: begin
                if (amount >= 8'd64) result = data[63] ? '1 : '0;
                else result = dataT'($signed(data) >>> amount);
            end
            opRol: result = (data << rot) | (data >> (8'd64 - rot));
            opRor: result = (data >> rot) | (data << (8'd64 - rot));
            default: result = 'x;
        endcase
        return result;
    endfunction

    task automatic waitCmdAck(input logic level);
        int count;
        count = 0;
        while (cmdAck !== level) begin
            @(negedge clk);
            count++;
            if (count > WaitLimit) abortRun($sformatf("timeout: cmdAck never went %0b", level));
        end
    endtask

    task automatic waitRspReq(input logic level);
        int count;
        count = 0;
        while (rspReq !== level) begin
            @(negedge clk);
            count++;
            if (count > WaitLimit) abortRun($sformatf("timeout: rspReq never went %0b", level));
        end
    endtask

    task automatic sendCommand(input int idx, input shiftOpT op, input dataT data,
                               input amountT amount);
        expQ.push_back(modelShift(op, data, amount));
        nameQ.push_back($sformatf("cmd %0d %s by %0d", idx, op.name(), amount));
        @(negedge clk);
        cmdOp     = op;
        cmdData   = data;
        cmdAmount = amount;
        cmdReq    = 1'b1;
        waitCmdAck(1'b1);
        cmdReq = 1'b0;  // Operands may change once the unit has let go
        waitCmdAck(1'b0);
    endtask

    initial begin : stimulus
        int          count;
        shiftOpT     op;
        dataT        data;
        amountT      amount;
        void'($urandom(Seed));
        arstN     = 1'b0;
        cmdReq    = 1'b0;
        cmdOp     = opSll;
        cmdData   = '0;
        cmdAmount = '0;
        repeat (4) @(posedge clk);
        @(negedge clk);
        arstN = 1'b1;
        for (int i = 0; i < NumCmds; i++) begin
            op   = shiftOpT'($urandom_range(4, 0));
            data = {$urandom, $urandom};
            case ($urandom_range(7, 0))
                0: amount = '0;
                1: amount = 8'd64;
                2, 3: amount = amountT'($urandom_range(255, 64));
                default: amount = amountT'($urandom_range(63, 0));
            endcase
            if ($urandom_range(9, 0) == 0) begin
                // Commands whose result has to come back as zero
                case ($urandom_range(2, 0))
                    0: data = '0;
                    1: begin
                        op     = opSll;
                        amount = amountT'($urandom_range(255, 64));
                    end
                    default: begin
                        op       = opSra;
                        data[63] = 1'b0;
                        amount   = amountT'($urandom_range(255, 64));
                    end
                endcase
            end
            sendCommand(i, op, data, amount);
        end
        count = 0;
        while (received < NumCmds) begin
            @(negedge clk);
            count++;
            if (count > WaitLimit) abortRun("timeout: responses stopped before the last command");
        end
        repeat (10) @(negedge clk);  // Give a stray response time to show up
        if (expQ.size() == 0 && !rspReq) begin
            $display("*** TEST PASSED ***");
            $finish;
        end else begin
            abortRun("commands left unanswered or an extra response appeared");
        end
    end

    // Consumer with random acknowledge delay for back-pressure
    initial begin : consumer
        string name;
        dataT  expected;
        rspAck   = 1'b0;
        received = 0;
        for (int i = 0; i < NumCmds; i++) begin
            waitRspReq(1'b1);
            repeat ($urandom_range(5, 0)) @(negedge clk);
            if (expQ.size() == 0) abortRun("response arrived with no command outstanding");
            name     = nameQ.pop_front();
            expected = expQ.pop_front();
            checkData(name, expected, rspData);
            checkZero({name, " zero flag"}, expected == '0, rspZero);
            rspAck = 1'b1;
            waitRspReq(1'b0);
            rspAck = 1'b0;
            received++;
        end
    end

endmodule

`default_nettype wire

// ==== shiftUnit.f ====
hdl/shiftPkg.sv
hdl/shiftLeft64.sv
hdl/shiftDecode.sv
hdl/shiftExecute.sv
hdl/shiftResult.sv
hdl/shiftUnit.sv
sim/shiftUnit_assert.sv
sim/shiftUnitTb.sv

// ==== Makefile ====
VERILATOR ?= verilator
FLAGS     = --binary --timing --assert -Wno-fatal -j 0
LINTFLAGS = --lint-only --timing -Wall
TOP       = shiftUnitTb
FILELIST  = shiftUnit.f
OBJDIR    = obj_dir

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJDIR)

run: build
	./$(OBJDIR)/V$(TOP)

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJDIR)
